// File: source/overlay_pkg.sv
package overlay_pkg;

   // --------------------
   // pixel and colour types
   // --------------------
   typedef logic [10:0] coord_t;      // hcount or vcount
   typedef logic [11:0] rgb_t;        // 4 bits per channel
   typedef logic [6:0]  char_code_t;  // 7-bit ascii
   typedef logic [63:0] glyph_t;      // row 0 in the top byte
   typedef logic [7:0]  glyph_row_t;  // bit 7 is the leftmost pixel

   // --------------------
   // text geometry
   // --------------------
   localparam int CHAR_W     = 8;   // cell width in pixels
   localparam int CHAR_H     = 16;  // 8x8 glyph, rows doubled
   localparam int LINE_CHARS = 15;  // label, six digits, unit, two spaces
   localparam int NUM_LINES  = 3;   // max, min, mean

   // layout reg, rom reg, mux reg
   localparam int PIPE_DEPTH = 3;

endpackage

// File: source/meas_pkg.sv
package meas_pkg;

   // --------------------
   // measurement values
   // --------------------
   typedef logic [11:0] sample_t;  // raw adc code
   typedef logic [13:0] mv_t;      // code * 3, up to 12285 mV

   // six bcd digits, most significant in the top nibble
   typedef logic [23:0] bcd_t;

   // --------------------
   // conversion constants
   // --------------------
   localparam int SCALE_MV   = 3;  // millivolts per adc code
   localparam int NUM_DIGITS = 6;

endpackage

// File: source/bin2bcd.sv
`timescale 1ns/1ns

module bin2bcd
   import meas_pkg::*;
(
   input  logic clk,
   input  logic rst,
   input  logic conv_req,
   input  mv_t  mv_in,
   output logic conv_ack,
   output bcd_t bcd_out
);

   localparam int SHIFTS = $bits(mv_t);  // one shift per input bit

   typedef enum logic [1:0] {
      IDLE,
      SHIFT,
      DONE
   } state_t;

   state_t     state;
   logic [3:0] shift_cnt;
   mv_t        bin_q;
   bcd_t       bcd_q;
   bcd_t       bcd_adj;

   // digits of five or more get three added before each shift
   always_comb begin
      bcd_adj = bcd_q;
      for (int d = 0; d < NUM_DIGITS; d++) begin
         if (bcd_q[4*d +: 4] >= 4'd5) begin
            bcd_adj[4*d +: 4] = bcd_q[4*d +: 4] + 4'd3;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= IDLE;
         shift_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               shift_cnt <= '0;
               if (conv_req) begin
                  state <= SHIFT;
               end
            end
            SHIFT: begin
               shift_cnt <= shift_cnt + 4'd1;
               if (shift_cnt == 4'(SHIFTS - 1)) begin
                  state <= DONE;
               end
            end
            DONE: begin
               if (!conv_req) begin  // four-phase release
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // shift register, loaded while idle
   always_ff @(posedge clk) begin
      if (state == IDLE) begin
         bin_q <= mv_in;
         bcd_q <= '0;
      end else if (state == SHIFT) begin
         {bcd_q, bin_q} <= {bcd_adj, bin_q} << 1;
      end
   end

   assign conv_ack = (state == DONE);
   assign bcd_out  = bcd_q;  // held stable in DONE

endmodule

// File: source/meas_capture.sv
`timescale 1ns/1ns

module meas_capture
   import meas_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    meas_req,
   input  sample_t max_code,
   input  sample_t min_code,
   input  sample_t mean_code,
   output logic    meas_ack,
   output bcd_t    max_bcd,
   output bcd_t    min_bcd,
   output bcd_t    mean_bcd
);

   typedef enum logic [1:0] {
      IDLE,     // wait for meas_req
      CONV,     // conv_req high, wait for conv_ack
      RELEASE,  // conv_req low, wait for conv_ack to drop
      ACK       // meas_ack high until meas_req falls
   } state_t;

   state_t     state;
   logic [1:0] sel;          // 0 max, 1 min, 2 mean
   sample_t    code_q [3];
   bcd_t       stage_q [3];
   mv_t        mv_in;
   logic       conv_req;
   logic       conv_ack;
   bcd_t       bcd_out;

   // scaled value of the code under conversion
   assign mv_in    = mv_t'(code_q[sel]) * mv_t'(SCALE_MV);
   assign conv_req = (state == CONV);
   assign meas_ack = (state == ACK);

   // single converter shared by the three values
   bin2bcd u_bin2bcd (
      .clk      (clk),
      .rst      (rst),
      .conv_req (conv_req),
      .mv_in    (mv_in),
      .conv_ack (conv_ack),
      .bcd_out  (bcd_out)
   );

   // --------------------
   // control and display registers
   // --------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         sel      <= '0;
         max_bcd  <= '0;
         min_bcd  <= '0;
         mean_bcd <= '0;
      end else begin
         case (state)
            IDLE: begin
               sel <= '0;
               if (meas_req) state <= CONV;
            end
            CONV: if (conv_ack) state <= RELEASE;
            RELEASE: begin
               if (!conv_ack) begin
                  if (sel == 2'd2) begin
                     // all three change together with meas_ack
                     max_bcd  <= stage_q[0];
                     min_bcd  <= stage_q[1];
                     mean_bcd <= stage_q[2];
                     state    <= ACK;
                  end else begin
                     sel   <= sel + 2'd1;
                     state <= CONV;
                  end
               end
            end
            ACK: if (!meas_req) state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   // codes latched on acceptance, results staged per value
   always_ff @(posedge clk) begin
      if (state == IDLE && meas_req) begin
         code_q[0] <= max_code;
         code_q[1] <= min_code;
         code_q[2] <= mean_code;
      end
      if (state == CONV && conv_ack) begin
         stage_q[sel] <= bcd_out;
      end
   end

endmodule

// File: source/text_layout.sv
`timescale 1ns/1ns

module text_layout
   import overlay_pkg::*;
   import meas_pkg::*;
#(
   parameter coord_t TEXT_X0 = 11'd768,
   parameter coord_t TEXT_Y0 = 11'd16
)(
   input  logic       clk,
   input  logic       rst,
   input  coord_t     hcount,
   input  coord_t     vcount,
   input  bcd_t       max_bcd,
   input  bcd_t       min_bcd,
   input  bcd_t       mean_bcd,
   output logic       text_on,
   output char_code_t char_code,
   output logic [2:0] glyph_row_sel,
   output logic [2:0] pixel_col
);

   localparam coord_t     BLOCK_W    = coord_t'(LINE_CHARS * CHAR_W);
   localparam coord_t     BLOCK_H    = coord_t'(NUM_LINES * CHAR_H);
   localparam char_code_t ASCII_ZERO = 7'h30;

   coord_t      dx;
   coord_t      dy;
   logic        in_block;
   logic [1:0]  line;
   logic [3:0]  char_idx;
   logic [39:0] label;      // five ascii characters
   bcd_t        line_bcd;
   char_code_t  char_next;

   // --------------------
   // region decode
   // --------------------
   assign dx       = hcount - TEXT_X0;
   assign dy       = vcount - TEXT_Y0;
   assign in_block = (hcount >= TEXT_X0) && (dx < BLOCK_W) &&
                     (vcount >= TEXT_Y0) && (dy < BLOCK_H);
   assign line     = dy[5:4];   // 16-pixel lines
   assign char_idx = dx[6:3];   // 8-pixel cells

   always_comb begin
      case (line)
         2'd0: begin
            label    = "Vmax=";
            line_bcd = max_bcd;
         end
         2'd1: begin
            label    = "Vmin=";
            line_bcd = min_bcd;
         end
         default: begin
            label    = "Vmea=";
            line_bcd = mean_bcd;
         end
      endcase
   end

   // character for the current cell
   always_comb begin
      if (char_idx < 4'd5) begin
         char_next = label[8*(4 - char_idx) +: 7];
      end else if (char_idx < 4'd11) begin
         char_next = ASCII_ZERO + char_code_t'(line_bcd[4*(10 - char_idx) +: 4]);
      end else if (char_idx == 4'd11) begin
         char_next = 7'h6d;  // m
      end else if (char_idx == 4'd12) begin
         char_next = 7'h56;  // V
      end else begin
         char_next = 7'h20;  // trailing spaces
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         text_on       <= 1'b0;
         char_code     <= '0;
         glyph_row_sel <= '0;
         pixel_col     <= '0;
      end else begin
         text_on       <= in_block;
         char_code     <= char_next;
         glyph_row_sel <= dy[3:1];  // each glyph row drawn twice
         pixel_col     <= dx[2:0];
      end
   end

endmodule

// File: source/font_rom.sv
`timescale 1ns/1ns

module font_rom
   import overlay_pkg::*;
(
   input  logic       clk,
   input  char_code_t char_code,
   input  logic [2:0] glyph_row_sel,
   output glyph_row_t glyph_row
);

   glyph_t glyph;

   // 8x8 bitmaps, top row first
   always_comb begin
      case (char_code)
         7'h30:   glyph = 64'h3C66_6E76_6666_3C00;  // 0
         7'h31:   glyph = 64'h1838_1818_1818_7E00;  // 1
         7'h32:   glyph = 64'h3C66_060C_3060_7E00;  // 2
         7'h33:   glyph = 64'h3C66_061C_0666_3C00;  // 3
         7'h34:   glyph = 64'h0C1C_3C6C_7E0C_0C00;  // 4
         7'h35:   glyph = 64'h7E60_7C06_0666_3C00;  // 5
         7'h36:   glyph = 64'h3C66_607C_6666_3C00;  // 6
         7'h37:   glyph = 64'h7E66_0C18_1818_1800;  // 7
         7'h38:   glyph = 64'h3C66_663C_6666_3C00;  // 8
         7'h39:   glyph = 64'h3C66_663E_0666_3C00;  // 9
         7'h3d:   glyph = 64'h0000_7E00_7E00_0000;  // =
         7'h56:   glyph = 64'h6666_6666_663C_1800;  // V
         7'h61:   glyph = 64'h0000_3C06_3E66_3E00;  // a
         7'h65:   glyph = 64'h0000_3C66_7E60_3C00;  // e
         7'h69:   glyph = 64'h1800_3818_1818_3C00;  // i
         7'h6d:   glyph = 64'h0000_667F_7F6B_6300;  // m
         7'h6e:   glyph = 64'h0000_7C66_6666_6600;  // n
         7'h78:   glyph = 64'h0000_663C_183C_6600;  // x
         default: glyph = '0;                       // blank
      endcase
   end

   // row 0 lives in bits 63:56
   always_ff @(posedge clk) begin
      glyph_row <= glyph[8*(7 - glyph_row_sel) +: 8];
   end

endmodule

// File: source/pixel_mux.sv
`timescale 1ns/1ns

module pixel_mux
   import overlay_pkg::*;
#(
   parameter rgb_t TEXT_RGB = 12'hAF0
)(
   input  logic       clk,
   input  logic       rst,
   input  logic       text_on,
   input  logic [2:0] pixel_col,
   input  glyph_row_t glyph_row,
   input  coord_t     hcount,
   input  coord_t     vcount,
   input  logic       hsync,
   input  logic       vsync,
   input  logic       hblnk,
   input  logic       vblnk,
   input  rgb_t       rgb_in,
   output coord_t     hcount_out,
   output coord_t     vcount_out,
   output logic       hsync_out,
   output logic       vsync_out,
   output logic       hblnk_out,
   output logic       vblnk_out,
   output rgb_t       rgb_out
);

   localparam int DLY   = PIPE_DEPTH - 1;  // stages ahead of the output reg
   localparam int VID_W = 2 * $bits(coord_t) + 4 + $bits(rgb_t);

   logic [VID_W-1:0] vid_in;
   logic [VID_W-1:0] vid_d [DLY];
   logic             text_on_d;
   logic [2:0]       pixel_col_d;
   logic             pix_bit;

   assign vid_in = {hcount, vcount, hsync, vsync, hblnk, vblnk, rgb_in};

   // --------------------
   // delay line
   // --------------------
   always_ff @(posedge clk) begin
      vid_d[0] <= vid_in;
      for (int s = 1; s < DLY; s++) begin
         vid_d[s] <= vid_d[s-1];
      end
      pixel_col_d <= pixel_col;  // joins at the last stage
   end

   // text_on arrives one cycle in, so one stage lines it up with the rom row
   always_ff @(posedge clk) begin
      if (rst) text_on_d <= 1'b0;
      else     text_on_d <= text_on;
   end

   assign pix_bit = glyph_row[3'd7 - pixel_col_d];  // msb leftmost

   always_ff @(posedge clk) begin
      if (rst) begin
         {hcount_out, vcount_out, hsync_out, vsync_out, hblnk_out, vblnk_out} <= '0;
         rgb_out <= '0;
      end else begin
         {hcount_out, vcount_out, hsync_out, vsync_out, hblnk_out, vblnk_out}
            <= vid_d[DLY-1][VID_W-1 -: VID_W - $bits(rgb_t)];
         if (text_on_d) rgb_out <= pix_bit ? TEXT_RGB : rgb_t'(0);
         else           rgb_out <= vid_d[DLY-1][$bits(rgb_t)-1:0];  // background video
      end
   end

endmodule

// File: source/meas_overlay.sv
`timescale 1ns/1ns

module meas_overlay
   import overlay_pkg::*;
   import meas_pkg::*;
#(
   parameter coord_t TEXT_X0  = 11'd768,
   parameter coord_t TEXT_Y0  = 11'd16,
   parameter rgb_t   TEXT_RGB = 12'hAF0   // yellow-green
)(
   input  logic    clk,
   input  logic    rst,
   input  logic    meas_req,
   input  sample_t max_code,
   input  sample_t min_code,
   input  sample_t mean_code,
   input  coord_t  hcount,
   input  coord_t  vcount,
   input  logic    hsync,
   input  logic    vsync,
   input  logic    hblnk,
   input  logic    vblnk,
   input  rgb_t    rgb_in,
   output logic    meas_ack,
   output coord_t  hcount_out,
   output coord_t  vcount_out,
   output logic    hsync_out,
   output logic    vsync_out,
   output logic    hblnk_out,
   output logic    vblnk_out,
   output rgb_t    rgb_out
);

   bcd_t       max_bcd;
   bcd_t       min_bcd;
   bcd_t       mean_bcd;
   logic       text_on;
   char_code_t char_code;
   logic [2:0] glyph_row_sel;
   logic [2:0] pixel_col;
   glyph_row_t glyph_row;

   meas_capture u_meas_capture (
      .clk, .rst, .meas_req, .max_code, .min_code, .mean_code,
      .meas_ack, .max_bcd, .min_bcd, .mean_bcd
   );

   // pixel path, three registered stages
   text_layout #(.TEXT_X0(TEXT_X0), .TEXT_Y0(TEXT_Y0)) u_text_layout (
      .clk, .rst, .hcount, .vcount, .max_bcd, .min_bcd, .mean_bcd,
      .text_on, .char_code, .glyph_row_sel, .pixel_col
   );

   font_rom u_font_rom (.clk, .char_code, .glyph_row_sel, .glyph_row);

   pixel_mux #(.TEXT_RGB(TEXT_RGB)) u_pixel_mux (
      .clk, .rst, .text_on, .pixel_col, .glyph_row,
      .hcount, .vcount, .hsync, .vsync, .hblnk, .vblnk, .rgb_in,
      .hcount_out, .vcount_out, .hsync_out, .vsync_out,
      .hblnk_out, .vblnk_out, .rgb_out
   );

endmodule

// File: tests/meas_overlay_tb.sv
`timescale 1ns/1ns

module meas_overlay_tb
   import overlay_pkg::*;
   import meas_pkg::*;
;

   localparam int   TEXT_X0     = 768;
   localparam int   TEXT_Y0     = 16;
   localparam rgb_t TEXT_RGB    = 12'hAF0;
   localparam int   MV_PER_CODE = 3;      // display value is code times three
   localparam int   ACK_WAIT    = 200;    // handshake cycle budget

   typedef struct packed {
      coord_t h;
      coord_t v;
      logic   hs;
      logic   vs;
      logic   hb;
      logic   vb;
      rgb_t   rgb;
   } pix_t;

   logic    clk = 1'b0;
   logic    rst;
   logic    meas_req;
   sample_t max_code, min_code, mean_code;
   coord_t  hcount, vcount;
   logic    hsync, vsync, hblnk, vblnk;
   rgb_t    rgb_in;
   logic    meas_ack;
   coord_t  hcount_out, vcount_out;
   logic    hsync_out, vsync_out, hblnk_out, vblnk_out;
   rgb_t    rgb_out;

   glyph_t      glyphs [128];      // font read from the pattern file
   sample_t     set_max [$];
   sample_t     set_min [$];
   sample_t     set_mean [$];
   sample_t     disp_codes [3];    // codes the screen should show now
   pix_t        pipe_q [$];        // pixels in flight
   logic [31:0] rng_state = 32'd46;
   int          cycle_count = 0;
   int          cycle_limit;
   logic        req_val;           // handshake values driven each cycle
   sample_t     max_val, min_val, mean_val;

   always #2 clk = ~clk;

   meas_overlay #(
      .TEXT_X0  (coord_t'(TEXT_X0)),
      .TEXT_Y0  (coord_t'(TEXT_Y0)),
      .TEXT_RGB (TEXT_RGB)
   ) u_meas_overlay (
      .clk, .rst, .meas_req, .max_code, .min_code, .mean_code,
      .hcount, .vcount, .hsync, .vsync, .hblnk, .vblnk, .rgb_in,
      .meas_ack, .hcount_out, .vcount_out, .hsync_out, .vsync_out,
      .hblnk_out, .vblnk_out, .rgb_out
   );

   // --------------------
   // helpers
   // --------------------
   function automatic logic [31:0] next_rand();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic expect_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      assert (act === exp)
      else abort_run($sformatf("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h",
                               $time, name, exp, act));
   endtask

   task automatic load_patterns();
      int          fd;
      int          code;
      logic [63:0] bits;
      logic [11:0] a, b, c;
      string       line;
      foreach (glyphs[i]) glyphs[i] = '0;   // unknown codes are blank
      fd = $fopen("tests/overlay_patterns.txt", "r");
      if (fd == 0) abort_run("cannot open tests/overlay_patterns.txt");
      while ($fgets(line, fd) != 0) begin
         if ($sscanf(line, "G %h %h", code, bits) == 2) begin
            glyphs[code[6:0]] = bits;
         end else if ($sscanf(line, "M %h %h %h", a, b, c) == 3) begin
            set_max.push_back(a);
            set_min.push_back(b);
            set_mean.push_back(c);
         end
      end
      $fclose(fd);
   endtask

   function automatic char_code_t expected_char(input int line, input int idx);
      string label;
      int    value;
      int    digit;
      case (line)
         0:       label = "Vmax=";
         1:       label = "Vmin=";
         default: label = "Vmea=";
      endcase
      value = int'(disp_codes[line]) * MV_PER_CODE;
      if (idx < 5) return char_code_t'(label[idx]);
      if (idx < 11) begin
         digit = (value / (10 ** (10 - idx))) % 10;   // msd at index 5
         return char_code_t'(48 + digit);             // ascii digit
      end
      if (idx == 11) return char_code_t'("m");
      if (idx == 12) return char_code_t'("V");
      return char_code_t'(" ");
   endfunction

   task automatic check_pixel(input pix_t p);
      int         dx, dy, line, idx, row, col;
      glyph_row_t row_bits;
      rgb_t       exp_rgb;
      expect_value("hcount_out", p.h, hcount_out);
      expect_value("vcount_out", p.v, vcount_out);
      expect_value("hsync_out", p.hs, hsync_out);
      expect_value("vsync_out", p.vs, vsync_out);
      expect_value("hblnk_out", p.hb, hblnk_out);
      expect_value("vblnk_out", p.vb, vblnk_out);
      dx = int'(p.h) - TEXT_X0;
      dy = int'(p.v) - TEXT_Y0;
      if (dx >= 0 && dx < 120 && dy >= 0 && dy < 48) begin
         line     = dy / 16;
         idx      = dx / 8;
         row      = (dy % 16) / 2;   // glyph rows doubled
         col      = dx % 8;
         row_bits = glyphs[expected_char(line, idx)][63 - 8*row -: 8];
         exp_rgb  = row_bits[7 - col] ? TEXT_RGB : rgb_t'(0);
      end else begin
         exp_rgb = p.rgb;   // background passes through
      end
      expect_value("rgb_out", exp_rgb, rgb_out);
   endtask

   // one pixel per cycle, outputs compared PIPE_DEPTH cycles later
   task automatic step_pixel(input coord_t h, input coord_t v);
      pix_t        p;
      logic [31:0] r;
      r = next_rand();
      @(posedge clk);
      p.h   = h;
      p.v   = v;
      p.hs  = r[12];
      p.vs  = r[13];
      p.hb  = r[14];
      p.vb  = r[15];
      p.rgb = r[11:0];
      hcount    <= p.h;
      vcount    <= p.v;
      hsync     <= p.hs;
      vsync     <= p.vs;
      hblnk     <= p.hb;
      vblnk     <= p.vb;
      rgb_in    <= p.rgb;
      meas_req  <= req_val;
      max_code  <= max_val;
      min_code  <= min_val;
      mean_code <= mean_val;
      pipe_q.push_back(p);
      @(negedge clk);
      cycle_count++;
      if (cycle_count > cycle_limit) abort_run("cycle limit reached, run is stuck");
      if (pipe_q.size() > PIPE_DEPTH) check_pixel(pipe_q.pop_front());
   endtask

   task automatic run_update(input sample_t mx, input sample_t mn, input sample_t me);
      int waited;
      assert (meas_ack === 1'b0)
      else abort_run("meas_ack is high before a new request");
      max_val  = mx;
      min_val  = mn;
      mean_val = me;
      req_val  = 1'b1;
      waited   = 0;
      do begin
         step_pixel('0, '0);
         waited++;
         if (waited > ACK_WAIT) abort_run("no meas_ack within 200 cycles of meas_req");
      end while (meas_ack !== 1'b1);
      req_val  = 1'b0;
      max_val  = sample_t'(next_rand());   // codes change once released
      min_val  = sample_t'(next_rand());
      mean_val = sample_t'(next_rand());
      step_pixel('0, '0);
      assert (meas_ack === 1'b1)
      else abort_run("meas_ack fell while meas_req was still high");
      step_pixel('0, '0);
      assert (meas_ack === 1'b0)
      else abort_run("meas_ack still high one cycle after meas_req fell");
      disp_codes[0] = mx;
      disp_codes[1] = mn;
      disp_codes[2] = me;
   endtask

   task automatic scan_block();
      for (int v = TEXT_Y0 - 4; v <= TEXT_Y0 + 51; v++) begin
         for (int h = TEXT_X0 - 8; h <= TEXT_X0 + 127; h++) begin
            step_pixel(coord_t'(h), coord_t'(v));
         end
      end
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin
      int          n_sets;
      logic [31:0] r;
      rst       = 1'b1;
      meas_req  = 1'b0;
      max_code  = '0;
      min_code  = '0;
      mean_code = '0;
      hcount    = '0;
      vcount    = '0;
      hsync     = 1'b0;
      vsync     = 1'b0;
      hblnk     = 1'b0;
      vblnk     = 1'b0;
      rgb_in    = '0;
      req_val   = 1'b0;
      max_val   = '0;
      min_val   = '0;
      mean_val  = '0;
      foreach (disp_codes[i]) disp_codes[i] = '0;   // reset shows zeros
      load_patterns();
      for (int i = 0; i < 4; i++) begin
         set_max.push_back(sample_t'(next_rand()));
         set_min.push_back(sample_t'(next_rand()));
         set_mean.push_back(sample_t'(next_rand()));
      end
      n_sets      = set_max.size();
      cycle_limit = (n_sets + 1) * (ACK_WAIT + 56 * 136) + 1000;   // first scan counts too

      // live inputs during reset
      for (int i = 0; i < 8; i++) begin
         r = next_rand();
         @(posedge clk);
         hcount    <= coord_t'(TEXT_X0 + i);   // inside the text block
         vcount    <= coord_t'(TEXT_Y0);
         hsync     <= r[12];
         vsync     <= r[13];
         hblnk     <= r[14];
         vblnk     <= r[15];
         rgb_in    <= r[11:0] | 12'h001;      // never black
         meas_req  <= 1'b1;
         max_code  <= r[27:16];
         min_code  <= r[31:20];
         mean_code <= r[23:12];
         @(negedge clk);
         expect_value("hcount_out", 0, hcount_out);
         expect_value("vcount_out", 0, vcount_out);
         expect_value("hsync_out", 0, hsync_out);
         expect_value("vsync_out", 0, vsync_out);
         expect_value("hblnk_out", 0, hblnk_out);
         expect_value("vblnk_out", 0, vblnk_out);
         expect_value("rgb_out", 0, rgb_out);
         expect_value("meas_ack", 0, meas_ack);
      end
      @(posedge clk);
      rst      <= 1'b0;
      meas_req <= 1'b0;

      scan_block();   // before any update
      for (int s = 0; s < n_sets; s++) begin
         run_update(set_max[s], set_min[s], set_mean[s]);
         scan_block();
      end
      repeat (PIPE_DEPTH) step_pixel('0, '0);   // drain the pipeline
      $display("TEST PASS");
      $finish;
   end

endmodule

// File: tests/overlay_patterns.txt
# G <ascii code hex> <64-bit glyph hex, row 0 in the top byte>
# M <max code hex> <min code hex> <mean code hex>, 12-bit adc codes
G 30 3C666E7666663C00
G 31 1838181818187E00
G 32 3C66060C30607E00
G 33 3C66061C06663C00
G 34 0C1C3C6C7E0C0C00
G 35 7E607C0606663C00
G 36 3C66607C66663C00
G 37 7E660C1818181800
G 38 3C66663C66663C00
G 39 3C66663E06663C00
G 3D 00007E007E000000
G 56 66666666663C1800
G 61 00003C063E663E00
G 65 00003C667E603C00
G 69 1800381818183C00
G 6D 0000667F7F6B6300
G 6E 00007C6666666600
G 78 0000663C183C6600

# measurement sets, extremes first
M FFF FFF FFF
M 000 000 000
M FFF 000 800
M 7D0 123 456
M 001 002 003
M A5A 5A5 3E8

// File: vlog.f
source/overlay_pkg.sv
source/meas_pkg.sv
source/bin2bcd.sv
source/meas_capture.sv
source/text_layout.sv
source/font_rom.sv
source/pixel_mux.sv
source/meas_overlay.sv
tests/meas_overlay_tb.sv

// File: Bender.yml
package:
  name: meas_overlay

sources:
  - source/overlay_pkg.sv
  - source/meas_pkg.sv
  - source/bin2bcd.sv
  - source/meas_capture.sv
  - source/text_layout.sv
  - source/font_rom.sv
  - source/pixel_mux.sv
  - source/meas_overlay.sv
  - target: test
    files:
      - tests/meas_overlay_tb.sv
